// ==== rtl/rename_config.svh ====
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// Reorder buffer entries, any depth above one
`define ROB_DEPTH 8

// Architectural registers seen by software
`define ARCH_REGS 8

// Physical registers, always more than ARCH_REGS
`define PHYS_REGS 32

`endif

// ==== rtl/rename_pkg.sv ====
`include "rename_config.svh"

package rename_pkg;

	// Physical register number
	typedef logic [$clog2(`PHYS_REGS)-1:0] phys_tag_t;

	// Architectural register number
	typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;

	// Index into the reorder buffer
	typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

	// Occupancy count, holds 0 up to ROB_DEPTH
	typedef logic [$clog2(`ROB_DEPTH+1)-1:0] rob_cnt_t;

	// Reorder buffer entry state
	typedef enum logic [1:0] {
		EMPTY,
		WAITING, // Renamed, result not yet on the bus
		DONE     // Result seen, ready to retire
	} rob_state_e;

endpackage

// ==== rtl/free_list.sv ====
`timescale 1ns/1ps
`include "rename_config.svh"

module free_list
	import rename_pkg::*;
(
	input  logic      clock,
	input  logic      arst_n,
	input  logic      alloc_en,        // Accepted dispatch takes alloc_tag
	input  logic      retire_en,
	input  phys_tag_t retire_tag,      // Now committed, used in the retired state
	input  phys_tag_t retire_free_tag, // Old mapping, released
	input  logic      flush,
	output phys_tag_t alloc_tag,
	output logic      free_empty
);

	// Tags below ARCH_REGS hold the initial identity mapping
	localparam logic [`PHYS_REGS-1:0] RESET_FREE =
		{{(`PHYS_REGS-`ARCH_REGS){1'b1}}, {`ARCH_REGS{1'b0}}};

	logic [`PHYS_REGS-1:0] spec_free; // 1 = free, speculative view
	logic [`PHYS_REGS-1:0] ret_free;  // 1 = free, retired view
	logic [`PHYS_REGS-1:0] spec_next;
	logic [`PHYS_REGS-1:0] ret_next;

	// Lowest free tag wins
	always_comb begin
		alloc_tag = '0;
		for (int i = `PHYS_REGS-1; i >= 0; i--) begin
			if (spec_free[i])
				alloc_tag = phys_tag_t'(i);
		end
	end

	assign free_empty = ~|spec_free;

	// Retired view changes only at retirement
	always_comb begin
		ret_next = ret_free;
		if (retire_en) begin
			ret_next[retire_free_tag] = 1'b1;
			ret_next[retire_tag]      = 1'b0;
		end
	end

	always_comb begin
		spec_next = spec_free;
		if (retire_en)
			spec_next[retire_free_tag] = 1'b1;
		if (alloc_en)
			spec_next[alloc_tag] = 1'b0;
		// Flush restores the retired view, including a retirement in this cycle
		if (flush)
			spec_next = ret_next;
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			spec_free <= RESET_FREE;
			ret_free  <= RESET_FREE;
		end else begin
			spec_free <= spec_next;
			ret_free  <= ret_next;
		end
	end

endmodule

// ==== rtl/map_table.sv ====
`timescale 1ns/1ps
`include "rename_config.svh"

module map_table
	import rename_pkg::*;
(
	input  logic                       clock,
	input  logic                       arst_n,
	input  logic                       write_en,    // Accepted dispatch
	input  arch_reg_t                  dest,
	input  phys_tag_t                  new_tag,
	input  logic                       flush,
	input  phys_tag_t [`ARCH_REGS-1:0] restore_map, // Committed map from arch_map
	output phys_tag_t                  old_tag
);

	phys_tag_t [`ARCH_REGS-1:0] map_q;

	// Current mapping of the destination, before this rename
	assign old_tag = map_q[dest];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			// Register r starts in tag r
			for (int i = 0; i < `ARCH_REGS; i++)
				map_q[i] <= phys_tag_t'(i);
		end else if (flush) begin
			map_q <= restore_map; // Drop all speculative renames
		end else if (write_en) begin
			map_q[dest] <= new_tag;
		end
	end

endmodule

// ==== rtl/rob_cam.sv ====
`timescale 1ns/1ps
`include "rename_config.svh"

module rob_cam
	import rename_pkg::*;
(
	input  logic                        cdb_valid,
	input  phys_tag_t                   cdb_tag,
	input  phys_tag_t  [`ROB_DEPTH-1:0] entry_tags,
	input  rob_state_e [`ROB_DEPTH-1:0] entry_states,
	output logic       [`ROB_DEPTH-1:0] hit
);

	// Only waiting entries can match, so stale tags in EMPTY or DONE slots are ignored
	always_comb begin
		hit = '0;
		if (cdb_valid) begin
			for (int i = 0; i < `ROB_DEPTH; i++)
				hit[i] = (entry_states[i] == WAITING) && (entry_tags[i] == cdb_tag);
		end
	end

endmodule

// ==== rtl/rob.sv ====
`timescale 1ns/1ps
`include "rename_config.svh"

module rob
	import rename_pkg::*;
(
	input  logic      clock,
	input  logic      arst_n,
	input  logic      dispatch_en,   // Already qualified by the stall
	input  arch_reg_t dispatch_dest,
	input  phys_tag_t new_tag,
	input  phys_tag_t old_tag,
	input  logic      cdb_valid,
	input  phys_tag_t cdb_tag,
	input  logic      flush,
	output logic      rob_full,
	output logic      retire_valid,
	output arch_reg_t retire_dest,
	output phys_tag_t retire_tag,
	output phys_tag_t retire_free_tag,
	output rob_cnt_t  rob_free_entries
);

	// Entry payload
	arch_reg_t  [`ROB_DEPTH-1:0] dest_q;
	phys_tag_t  [`ROB_DEPTH-1:0] new_tag_q;
	phys_tag_t  [`ROB_DEPTH-1:0] old_tag_q;

	// Entry control
	rob_state_e [`ROB_DEPTH-1:0] state_q;
	rob_idx_t                    head;  // Oldest entry
	rob_idx_t                    tail;  // Next free slot
	rob_cnt_t                    count;

	logic       [`ROB_DEPTH-1:0] hit;

	// Wraps at ROB_DEPTH, which need not be a power of two
	function automatic rob_idx_t next_idx(input rob_idx_t idx);
		return (idx == rob_idx_t'(`ROB_DEPTH-1)) ? '0 : idx + 1'b1;
	endfunction

	rob_cam u_cam (
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.entry_tags   (new_tag_q),
		.entry_states (state_q),
		.hit          (hit)
	);

	assign rob_full         = (count == rob_cnt_t'(`ROB_DEPTH));
	assign rob_free_entries = rob_cnt_t'(`ROB_DEPTH) - count;

	// Head retires in the same cycle it is seen DONE
	assign retire_valid    = (state_q[head] == DONE);
	assign retire_dest     = dest_q[head];
	assign retire_tag      = new_tag_q[head];
	assign retire_free_tag = old_tag_q[head];

	always_ff @(posedge clock) begin
		if (dispatch_en) begin
			dest_q[tail]    <= dispatch_dest;
			new_tag_q[tail] <= new_tag;
			old_tag_q[tail] <= old_tag;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `ROB_DEPTH; i++)
				state_q[i] <= EMPTY;
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else if (flush) begin
			// Mispredict empties the whole buffer
			for (int i = 0; i < `ROB_DEPTH; i++)
				state_q[i] <= EMPTY;
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			// Completion marking
			for (int i = 0; i < `ROB_DEPTH; i++) begin
				if (hit[i])
					state_q[i] <= DONE;
			end

			if (retire_valid) begin
				state_q[head] <= EMPTY;
				head          <= next_idx(head);
			end

			// Tail slot is EMPTY here, never a CAM hit
			if (dispatch_en) begin
				state_q[tail] <= WAITING;
				tail          <= next_idx(tail);
			end

			unique case ({dispatch_en, retire_valid})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

endmodule

// ==== rtl/arch_map.sv ====
`timescale 1ns/1ps
`include "rename_config.svh"

module arch_map
	import rename_pkg::*;
(
	input  logic                       clock,
	input  logic                       arst_n,
	input  logic                       retire_en,
	input  arch_reg_t                  retire_dest,
	input  phys_tag_t                  retire_tag,
	output phys_tag_t [`ARCH_REGS-1:0] arch_table
);

	phys_tag_t [`ARCH_REGS-1:0] arch_q; // Committed state after the last edge

	// A retirement in this cycle is forwarded, so a flush at the same edge
	// restores the map with it already applied
	always_comb begin
		arch_table = arch_q;
		if (retire_en)
			arch_table[retire_dest] = retire_tag;
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `ARCH_REGS; i++)
				arch_q[i] <= phys_tag_t'(i); // Identity map
		end else begin
			arch_q <= arch_table;
		end
	end

endmodule

// ==== rtl/rename_top.sv ====
`timescale 1ns/1ps
`include "rename_config.svh"

module rename_top
	import rename_pkg::*;
(
	input  logic      clock,
	input  logic      arst_n,
	input  logic      dispatch_en,
	input  arch_reg_t dispatch_dest,
	input  logic      cdb_valid,
	input  phys_tag_t cdb_tag,
	input  logic      flush,
	output logic      dispatch_stall,
	output phys_tag_t dispatch_tag,
	output phys_tag_t dispatch_old_tag,
	output logic      retire_valid,
	output arch_reg_t retire_dest,
	output phys_tag_t retire_tag,
	output phys_tag_t retire_free_tag,
	output rob_cnt_t  rob_free_entries
);

	logic                       free_empty;
	logic                       rob_full;
	logic                       dispatch_ok;
	phys_tag_t [`ARCH_REGS-1:0] arch_table;

	// No free tag or no free entry refuses the dispatch
	assign dispatch_stall = free_empty | rob_full;
	assign dispatch_ok    = dispatch_en & ~dispatch_stall;

	free_list u_free_list (
		.clock           (clock),
		.arst_n          (arst_n),
		.alloc_en        (dispatch_ok),
		.retire_en       (retire_valid),
		.retire_tag      (retire_tag),
		.retire_free_tag (retire_free_tag),
		.flush           (flush),
		.alloc_tag       (dispatch_tag),
		.free_empty      (free_empty)
	);

	map_table u_map_table (
		.clock       (clock),
		.arst_n      (arst_n),
		.write_en    (dispatch_ok),
		.dest        (dispatch_dest),
		.new_tag     (dispatch_tag),
		.flush       (flush),
		.restore_map (arch_table),
		.old_tag     (dispatch_old_tag)
	);

	rob u_rob (
		.clock            (clock),
		.arst_n           (arst_n),
		.dispatch_en      (dispatch_ok),
		.dispatch_dest    (dispatch_dest),
		.new_tag          (dispatch_tag),
		.old_tag          (dispatch_old_tag),
		.cdb_valid        (cdb_valid),
		.cdb_tag          (cdb_tag),
		.flush            (flush),
		.rob_full         (rob_full),
		.retire_valid     (retire_valid),
		.retire_dest      (retire_dest),
		.retire_tag       (retire_tag),
		.retire_free_tag  (retire_free_tag),
		.rob_free_entries (rob_free_entries)
	);

	arch_map u_arch_map (
		.clock       (clock),
		.arst_n      (arst_n),
		.retire_en   (retire_valid),
		.retire_dest (retire_dest),
		.retire_tag  (retire_tag),
		.arch_table  (arch_table)
	);

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clock,
	output logic arst_n
);

	localparam time HALF_PERIOD  = 50ns; // 100 ns clock
	localparam int  RESET_CYCLES = 16;

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	// Release on a falling edge, away from the active edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;
	end

endmodule

// ==== dv/rename_tb.sv ====
`timescale 1ns/1ps
`include "rename_config.svh"

module rename_tb
	import rename_pkg::*;
();

	localparam int RETIRE_TIMEOUT = 20;
	localparam int DRAIN_TIMEOUT  = 40;
	localparam int RESET_TIMEOUT  = 40;

	typedef enum {OP_DISPATCH, OP_COMPLETE, OP_COMPLETE_TAG, OP_FLUSH, OP_IDLE,
		OP_WAIT_RETIRE, OP_DRAIN} op_e;

	logic      clock;
	logic      arst_n;
	logic      dispatch_en;
	arch_reg_t dispatch_dest;
	logic      cdb_valid;
	phys_tag_t cdb_tag;
	logic      flush;
	logic      dispatch_stall;
	phys_tag_t dispatch_tag;
	phys_tag_t dispatch_old_tag;
	logic      retire_valid;
	arch_reg_t retire_dest;
	phys_tag_t retire_tag;
	phys_tag_t retire_free_tag;
	rob_cnt_t  rob_free_entries;

	// Stimulus table, an expected value of -1 means none
	op_e row_op[$];
	int  row_arg[$];
	int  row_exp[$];

	// Reference model state
	logic [`PHYS_REGS-1:0] m_spec_free; // 1 = free
	logic [`PHYS_REGS-1:0] m_ret_free;
	int                    m_spec_map[`ARCH_REGS];
	int                    m_arch_map[`ARCH_REGS];
	int                    q_dest[$];  // Entry queue, oldest at the front
	int                    q_new[$];
	int                    q_old[$];
	bit                    q_done[$];

	logic [31:0] lcg_state     = 32'h277c;
	int          error_count   = 0;
	int          timeout_count = 0;
	logic        seen_retire;
	int          seen_free;

	tb_clock_gen u_clock_gen (
		.clock  (clock),
		.arst_n (arst_n)
	);

	rename_top dut0 (
		.clock            (clock),
		.arst_n           (arst_n),
		.dispatch_en      (dispatch_en),
		.dispatch_dest    (dispatch_dest),
		.cdb_valid        (cdb_valid),
		.cdb_tag          (cdb_tag),
		.flush            (flush),
		.dispatch_stall   (dispatch_stall),
		.dispatch_tag     (dispatch_tag),
		.dispatch_old_tag (dispatch_old_tag),
		.retire_valid     (retire_valid),
		.retire_dest      (retire_dest),
		.retire_tag       (retire_tag),
		.retire_free_tag  (retire_free_tag),
		.rob_free_entries (rob_free_entries)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic int lowest_free(input logic [`PHYS_REGS-1:0] bits);
		for (int i = 0; i < `PHYS_REGS; i++) begin
			if (bits[i])
				return i;
		end
		return -1;
	endfunction

	// Tag of a random WAITING entry, -1 if there is none
	function automatic int pick_waiting();
		int idx[$];
		for (int i = 0; i < q_done.size(); i++) begin
			if (!q_done[i])
				idx.push_back(i);
		end
		if (idx.size() == 0)
			return -1;
		lcg_state = lcg_step(lcg_state);
		return q_new[idx[(lcg_state >> 16) % idx.size()]];
	endfunction

	task automatic add_row(input op_e op, input int arg, input int exp);
		row_op.push_back(op);
		row_arg.push_back(arg);
		row_exp.push_back(exp);
	endtask

	task automatic report_mismatch(input string name, input int exp, input logic [31:0] act);
		error_count++;
		$display("ERROR t=%0t %s expected %0d actual %0d", $time, name, exp, act);
	endtask

	// Outputs settle well before the falling edge
	task automatic check_outputs(input int exp_tag, input int exp_free,
		output bit stall, output bit retire);
		int dest;
		dest   = int'(dispatch_dest);
		stall  = (m_spec_free == '0) || (q_new.size() == `ROB_DEPTH);
		retire = (q_done.size() > 0) && q_done[0];
		if (dispatch_stall !== stall)
			report_mismatch("dispatch_stall", stall, dispatch_stall);
		if (!stall && dispatch_tag !== phys_tag_t'(lowest_free(m_spec_free)))
			report_mismatch("dispatch_tag", lowest_free(m_spec_free), dispatch_tag);
		if (exp_tag >= 0 && dispatch_tag !== phys_tag_t'(exp_tag))
			report_mismatch("dispatch_tag", exp_tag, dispatch_tag);
		if (dispatch_old_tag !== phys_tag_t'(m_spec_map[dest]))
			report_mismatch("dispatch_old_tag", m_spec_map[dest], dispatch_old_tag);
		if (rob_free_entries !== rob_cnt_t'(`ROB_DEPTH - q_new.size()))
			report_mismatch("rob_free_entries", `ROB_DEPTH - q_new.size(), rob_free_entries);
		if (exp_free >= 0 && rob_free_entries !== rob_cnt_t'(exp_free))
			report_mismatch("rob_free_entries", exp_free, rob_free_entries);
		if (retire_valid !== retire)
			report_mismatch("retire_valid", retire, retire_valid);
		if (retire) begin
			if (retire_dest !== arch_reg_t'(q_dest[0]))
				report_mismatch("retire_dest", q_dest[0], retire_dest);
			if (retire_tag !== phys_tag_t'(q_new[0]))
				report_mismatch("retire_tag", q_new[0], retire_tag);
			if (retire_free_tag !== phys_tag_t'(q_old[0]))
				report_mismatch("retire_free_tag", q_old[0], retire_free_tag);
		end
	endtask

	// Model one clock edge; retirement comes before a flush in the same cycle
	task automatic update_model(input bit en, input int dest, input bit cv, input int ctag,
		input bit fl, input bit stall, input bit retire);
		int tag;
		tag = lowest_free(m_spec_free);
		if (retire) begin
			m_ret_free[q_old[0]]  = 1'b1;
			m_ret_free[q_new[0]]  = 1'b0;
			m_spec_free[q_old[0]] = 1'b1;
			m_arch_map[q_dest[0]] = q_new[0];
			void'(q_dest.pop_front());
			void'(q_new.pop_front());
			void'(q_old.pop_front());
			void'(q_done.pop_front());
		end
		if (fl) begin
			q_dest.delete();
			q_new.delete();
			q_old.delete();
			q_done.delete();
			m_spec_map  = m_arch_map;
			m_spec_free = m_ret_free;
		end else begin
			for (int i = 0; i < q_new.size(); i++) begin
				if (cv && !q_done[i] && q_new[i] == ctag)
					q_done[i] = 1'b1;
			end
			if (en && !stall) begin
				q_dest.push_back(dest);
				q_new.push_back(tag);
				q_old.push_back(m_spec_map[dest]);
				q_done.push_back(1'b0);
				m_spec_free[tag] = 1'b0;
				m_spec_map[dest] = tag;
			end
		end
	endtask

	// Starts just after a rising edge and ends on the next one
	task automatic run_cycle(input bit en, input int dest, input bit cv, input int ctag,
		input bit fl, input int exp_tag, input int exp_free);
		bit stall;
		bit retire;
		#1;
		dispatch_en   = en;
		dispatch_dest = arch_reg_t'(dest);
		cdb_valid     = cv;
		cdb_tag       = phys_tag_t'(ctag);
		flush         = fl;
		@(negedge clock);
		check_outputs(exp_tag, exp_free, stall, retire);
		seen_retire = retire_valid;
		seen_free   = rob_free_entries;
		@(posedge clock);
		update_model(en, dest, cv, ctag, fl, stall, retire);
	endtask

	task automatic wait_retire();
		int n;
		n           = 0;
		seen_retire = 1'b0;
		while (seen_retire !== 1'b1 && n < RETIRE_TIMEOUT) begin
			run_cycle(0, 0, 0, 0, 0, -1, -1);
			n++;
		end
		if (seen_retire !== 1'b1) begin
			timeout_count++;
			$display("Timed out after %0d cycles waiting for retire_valid", n);
		end
	endtask

	task automatic drain_rob();
		int n;
		n         = 0;
		seen_free = -1;
		while (seen_free != `ROB_DEPTH && n < DRAIN_TIMEOUT) begin
			run_cycle(0, 0, 0, 0, 0, -1, -1);
			n++;
		end
		if (seen_free != `ROB_DEPTH) begin
			timeout_count++;
			$display("Timed out after %0d cycles waiting for the reorder buffer to drain", n);
		end
	endtask

	task automatic apply_row(input int r);
		int tag;
		case (row_op[r])
			OP_DISPATCH:     run_cycle(1, row_arg[r], 0, 0, 0, row_exp[r], -1);
			OP_COMPLETE_TAG: run_cycle(0, 0, 1, row_arg[r], 0, -1, -1);
			OP_FLUSH:        run_cycle(0, 0, 0, 0, 1, -1, -1);
			OP_IDLE:         run_cycle(0, 0, 0, 0, 0, -1, row_exp[r]);
			OP_WAIT_RETIRE:  wait_retire();
			OP_DRAIN:        drain_rob();
			OP_COMPLETE: begin
				// Argument is the entry age, or -1 for a random waiting entry
				if (row_arg[r] < 0)
					tag = pick_waiting();
				else if (row_arg[r] < q_new.size())
					tag = q_new[row_arg[r]];
				else
					tag = -1;
				if (tag < 0) begin
					error_count++;
					$display("Row %0d names no reorder buffer entry to complete", r);
				end else begin
					run_cycle(0, 0, 1, tag, 0, -1, -1);
				end
			end
			default: ;
		endcase
	endtask

	task automatic build_table();
		for (int i = 0; i < 4; i++)
			add_row(OP_DISPATCH, i, `ARCH_REGS + i); // Fresh tags in order
		add_row(OP_DISPATCH, 0, `ARCH_REGS + 4);
		add_row(OP_COMPLETE, 3, -1);                  // Younger entries first
		add_row(OP_COMPLETE, 1, -1);
		add_row(OP_IDLE, 0, `ROB_DEPTH - 5);          // Head still waiting
		for (int i = 0; i < 3; i++)
			add_row(OP_COMPLETE, -1, -1);
		add_row(OP_DRAIN, 0, -1);
		add_row(OP_DISPATCH, 5, 0);                   // Tag 0 was freed by r0
		add_row(OP_COMPLETE, 0, -1);
		add_row(OP_DRAIN, 0, -1);
		// Fill the buffer with nothing completed
		for (int i = 0; i < `ROB_DEPTH; i++)
			add_row(OP_DISPATCH, i % `ARCH_REGS, -1);
		add_row(OP_IDLE, 0, 0);
		add_row(OP_DISPATCH, 1, -1);                  // Refused by the stall
		add_row(OP_IDLE, 0, 0);
		add_row(OP_COMPLETE, 0, -1);
		add_row(OP_WAIT_RETIRE, 0, -1);
		add_row(OP_IDLE, 0, 1);
		// Unknown tag, then a second completion of a DONE entry
		add_row(OP_COMPLETE_TAG, `PHYS_REGS - 1, -1);
		add_row(OP_COMPLETE, 2, -1);
		add_row(OP_COMPLETE, 2, -1);
		add_row(OP_IDLE, 0, 1);
		add_row(OP_IDLE, 0, 1);
		add_row(OP_FLUSH, 0, -1);
		add_row(OP_IDLE, 0, `ROB_DEPTH);
		for (int i = 0; i < 3; i++)
			add_row(OP_DISPATCH, i, -1);
		for (int i = 0; i < 3; i++)
			add_row(OP_COMPLETE, -1, -1);
		add_row(OP_DRAIN, 0, -1);
	endtask

	initial begin
		int n;
		dispatch_en   = 1'b0;
		dispatch_dest = '0;
		cdb_valid     = 1'b0;
		cdb_tag       = '0;
		flush         = 1'b0;
		// Identity map, tags from ARCH_REGS upward free
		for (int i = 0; i < `PHYS_REGS; i++) begin
			m_spec_free[i] = (i >= `ARCH_REGS);
			m_ret_free[i]  = (i >= `ARCH_REGS);
		end
		for (int i = 0; i < `ARCH_REGS; i++) begin
			m_spec_map[i] = i;
			m_arch_map[i] = i;
		end
		build_table();
		n = 0;
		while (arst_n !== 1'b1 && n < RESET_TIMEOUT) begin
			@(posedge clock);
			n++;
		end
		if (arst_n !== 1'b1) begin
			timeout_count++;
			$display("Reset was not released within %0d cycles", RESET_TIMEOUT);
		end else begin
			for (int r = 0; r < row_op.size(); r++)
				apply_row(r);
		end
		$display("Result: %0d value errors, %0d timeouts", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+rtl
rtl/rename_pkg.sv
rtl/free_list.sv
rtl/map_table.sv
rtl/rob_cam.sv
rtl/rob.sv
rtl/arch_map.sv
rtl/rename_top.sv
dv/tb_clock_gen.sv
dv/rename_tb.sv
